/* all.f */
hdl/oled_pkg.sv
hdl/oled_power_seq.sv
hdl/oled_spi_tx.sv
hdl/button_ctrl.sv
hdl/snake_engine.sv
hdl/pixel_ram.sv
hdl/frame_writer.sv
hdl/oled_snake_top.sv
dv/tb_oled_snake.sv

/* dv/snake_stimulus.txt */
# init <twelve power-up command bytes in hex, in send order>
# frames <number of frames checked>
# <frame> <button>   button pressed and released just before that frame
init AE 8D 14 D9 F1 81 0F A0 C0 DA 00 AF
frames 21
# frames 0 and 1 stay blank
2 display
# up wraps page 0 row 0 to page 3 row 7
3 up
# down runs back across the page 3 to page 0 boundary
5 down
# left from column 9 runs across column 0 to 127
8 left
# snake frozen from here on
19 display
20 right

/* dv/tb_oled_snake.sv */
`timescale 1ns/10ps

module tb_oled_snake;

	localparam int BYTE_TIMEOUT  = 10000;	// clk cycles, covers a full redraw
	localparam int READY_TIMEOUT = 1000;

	logic clk;
	logic rstn;
	logic display;
	logic mv_l;
	logic mv_r;
	logic mv_u;
	logic mv_d;
	logic oled_res;
	logic oled_dc;
	logic oled_sclk;
	logic oled_sdin;
	logic oled_vbat;
	logic oled_vdd;
	logic ready;

	int   errors = 0;
	logic timed_out = 1'b0;

	logic [8:0] rx_q [$];	// {dc, data} per decoded byte
	logic [7:0] rx_shift = '0;
	int         rx_bits = 0;
	int         rx_count = 0;

	int vdd_falls = 0;
	int vdd_fall_at = -1;
	int res_falls = 0;
	int res_fall_at = -1;
	int vbat_falls = 0;
	int vbat_fall_at = -1;
	int ready_at = -1;

	logic [7:0] init_bytes [0:11];
	int         ev_frame [$];
	string      ev_pin [$];
	int         n_frames;

	// reference snake, cell 0 is the head
	int         body_page [0:9];
	int         body_col [0:9];
	int         body_row [0:9];
	logic [7:0] exp_img [0:3][0:127];
	string      model_dir;
	logic       model_on;
	logic       model_pend;
	logic       model_shown;

	oled_snake_top #(
		.vdd_wait(50),
		.res_low(40),
		.vbat_wait(60),
		.frame_gap(200)
	) i_oled_snake_top (
		.clk(clk), .rstn(rstn), .display(display),
		.mv_l(mv_l), .mv_r(mv_r), .mv_u(mv_u), .mv_d(mv_d),
		.oled_res(oled_res), .oled_dc(oled_dc), .oled_sclk(oled_sclk),
		.oled_sdin(oled_sdin), .oled_vbat(oled_vbat), .oled_vdd(oled_vdd),
		.ready(ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// serial decoder, MSB first
	always @(posedge oled_sclk) begin
		if (rstn === 1'b1) begin
			rx_shift = {rx_shift[6:0], oled_sdin};
			rx_bits++;
			if (rx_bits == 8) begin
				rx_q.push_back({oled_dc, rx_shift});
				rx_count++;
				rx_bits = 0;
			end
		end
	end

	// power pins, tagged with the number of bytes already seen
	always @(negedge oled_vdd) begin
		if (rstn === 1'b1) begin
			vdd_falls++;
			vdd_fall_at = rx_count;
		end
	end

	always @(negedge oled_res) begin
		if (rstn === 1'b1) begin
			res_falls++;
			res_fall_at = rx_count;
		end
	end

	always @(negedge oled_vbat) begin
		if (rstn === 1'b1) begin
			vbat_falls++;
			vbat_fall_at = rx_count;
		end
	end

	always @(posedge ready) begin
		if (rstn === 1'b1)
			ready_at = rx_count;
	end

	task automatic check_bit(input string name, input logic got, input logic exp_val);
		if (got !== exp_val) begin
			$display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp_val);
			errors++;
		end
	endtask

	task automatic load_stimulus(output logic ok);
		int    fd;
		int    fr;
		int    n;
		string line;
		string key;
		string pin;
		ok = 1'b0;
		n_frames = 0;
		fd = $fopen("dv/snake_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/snake_stimulus.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line.getc(0) == "#")
				continue;	// blank or comment line
			n = $sscanf(line, "%s", key);
			if (key == "init") begin
				n = $sscanf(line, "init %h %h %h %h %h %h %h %h %h %h %h %h",
					init_bytes[0], init_bytes[1], init_bytes[2], init_bytes[3],
					init_bytes[4], init_bytes[5], init_bytes[6], init_bytes[7],
					init_bytes[8], init_bytes[9], init_bytes[10], init_bytes[11]);
				if (n != 12) begin
					$display("init line of the stimulus file holds %0d bytes, not 12", n);
					errors++;
				end
			end else if (key == "frames")
				n = $sscanf(line, "frames %d", n_frames);
			else begin
				n = $sscanf(line, "%d %s", fr, pin);
				ev_frame.push_back(fr);
				ev_pin.push_back(pin);
			end
		end
		$fclose(fd);
		ok = (n_frames > 0);
		if (!ok) begin
			$display("stimulus file gives no frame count");
			errors++;
		end
	endtask

	// press, hold two cycles, release
	task automatic pulse_pin(input string pin);
		@(posedge clk);
		if (pin == "display")
			display <= 1'b1;
		else if (pin == "left")
			mv_l <= 1'b1;
		else if (pin == "right")
			mv_r <= 1'b1;
		else if (pin == "up")
			mv_u <= 1'b1;
		else if (pin == "down")
			mv_d <= 1'b1;
		else begin
			$display("unknown button %s in the stimulus file", pin);
			errors++;
		end
		repeat (2) @(posedge clk);
		display <= 1'b0;
		mv_l    <= 1'b0;
		mv_r    <= 1'b0;
		mv_u    <= 1'b0;
		mv_d    <= 1'b0;
		repeat (4) @(posedge clk);	// let the release settle
	endtask

	task automatic place_body();
		for (int i = 0; i < 10; i++) begin
			body_page[i] = 0;
			body_row[i]  = 0;
			body_col[i]  = 9 - i;
		end
	endtask

	task automatic move_body();
		for (int i = 9; i > 0; i--) begin
			body_page[i] = body_page[i-1];
			body_col[i]  = body_col[i-1];
			body_row[i]  = body_row[i-1];
		end
		if (model_dir == "right")
			body_col[0] = (body_col[0] + 1) % 128;
		else if (model_dir == "left")
			body_col[0] = (body_col[0] + 127) % 128;
		else if (model_dir == "down") begin
			if (body_row[0] == 7) begin
				body_row[0]  = 0;
				body_page[0] = (body_page[0] + 1) % 4;
			end else
				body_row[0] = body_row[0] + 1;
		end else begin
			if (body_row[0] == 0) begin
				body_row[0]  = 7;
				body_page[0] = (body_page[0] + 3) % 4;
			end else
				body_row[0] = body_row[0] - 1;
		end
	endtask

	task automatic build_image();
		for (int p = 0; p < 4; p++)
			for (int c = 0; c < 128; c++)
				exp_img[p][c] = 8'h00;
		if (model_shown)
			for (int i = 0; i < 10; i++)
				exp_img[body_page[i]][body_col[i]][body_row[i]] = 1'b1;
	endtask

	task automatic check_byte(input logic [7:0] exp_data, input logic exp_dc, input string what);
		int         waited;
		logic [8:0] got;
		if (timed_out)
			return;
		waited = 0;
		while (rx_q.size() == 0 && waited < BYTE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (rx_q.size() == 0) begin
			$display("timeout: no byte on the serial lines while waiting for %s", what);
			timed_out = 1'b1;
			return;
		end
		got = rx_q.pop_front();
		if (got[7:0] !== exp_data) begin
			$display("** Error oled_sdin byte (%s): got 0x%02h, expected 0x%02h",
				what, got[7:0], exp_data);
			errors++;
		end
		if (got[8] !== exp_dc) begin
			$display("** Error oled_dc (%s): got 0x%0h, expected 0x%0h", what, got[8], exp_dc);
			errors++;
		end
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (ready !== 1'b1 && waited < READY_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (ready !== 1'b1) begin
			$display("timeout: ready did not rise after the last init byte");
			timed_out = 1'b1;
		end
	endtask

	task automatic check_power_up();
		for (int k = 0; k < 12; k++)
			check_byte(init_bytes[k], 1'b0, $sformatf("init byte %0d", k));
		if (timed_out)
			return;
		wait_ready();
		if (vdd_falls != 1 || vdd_fall_at != 0) begin
			$display("oled_vdd did not fall once before the first byte");
			errors++;
		end
		if (res_falls != 1 || res_fall_at != 1) begin
			$display("oled_res did not pulse low once between the first and second bytes");
			errors++;
		end
		if (vbat_falls != 1 || vbat_fall_at != 5) begin
			$display("oled_vbat did not fall right before the sixth byte");
			errors++;
		end
		if (ready_at != 12) begin
			$display("ready did not rise right after the twelfth byte");
			errors++;
		end
	endtask

	task automatic check_frames();
		for (int f = 0; f < n_frames; f++) begin
			if (timed_out)
				return;
			for (int e = 0; e < ev_frame.size(); e++) begin
				if (ev_frame[e] == f) begin
					pulse_pin(ev_pin[e]);
					if (ev_pin[e] == "display") begin
						model_on = !model_on;
						if (model_on)
							model_pend = 1'b1;	// start body at next frame
					end else
						model_dir = ev_pin[e];
				end
			end
			if (model_pend) begin
				place_body();
				model_pend  = 1'b0;
				model_shown = 1'b1;
			end else if (model_on && model_shown)
				move_body();
			build_image();
			check_byte(8'h20, 1'b0, $sformatf("frame %0d addressing mode", f));
			check_byte(8'h10, 1'b0, $sformatf("frame %0d page mode", f));
			for (int p = 0; p < 4; p++) begin
				check_byte(8'h22, 1'b0, $sformatf("frame %0d page %0d command", f, p));
				check_byte(8'(p), 1'b0, $sformatf("frame %0d page %0d number", f, p));
				check_byte(8'h00, 1'b0, $sformatf("frame %0d page %0d column low", f, p));
				check_byte(8'h10, 1'b0, $sformatf("frame %0d page %0d column high", f, p));
				for (int c = 0; c < 128; c++)
					check_byte(exp_img[p][c], 1'b1,
						$sformatf("frame %0d page %0d column %0d", f, p, c));
			end
		end
	endtask

	initial begin
		logic ok;
		rstn        = 1'b0;
		display     = 1'b0;
		mv_l        = 1'b0;
		mv_r        = 1'b0;
		mv_u        = 1'b0;
		mv_d        = 1'b0;
		model_dir   = "right";
		model_on    = 1'b0;
		model_pend  = 1'b0;
		model_shown = 1'b0;
		load_stimulus(ok);
		repeat (10) @(posedge clk);
		@(negedge clk);
		check_bit("oled_vdd", oled_vdd, 1'b1);
		check_bit("oled_vbat", oled_vbat, 1'b1);
		check_bit("oled_res", oled_res, 1'b1);
		check_bit("oled_sclk", oled_sclk, 1'b1);
		check_bit("ready", ready, 1'b0);
		@(posedge clk);
		rstn <= 1'b1;
		if (ok) begin
			check_power_up();
			check_frames();
		end
		$display("errors: %0d, timeouts: %0d", errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* hdl/button_ctrl.sv */
`timescale 1ns/10ps

module button_ctrl (
	input  logic       clk,
	input  logic       rstn,
	input  logic       mv_l,
	input  logic       mv_r,
	input  logic       mv_u,
	input  logic       mv_d,
	input  logic       display,
	output logic [1:0] dir,
	output logic       game_on
);
	import oled_pkg::*;

	logic [4:0] btn_sync;	// {display, d, u, l, r}
	logic [4:0] btn_prev;
	logic [4:0] released;

	assign released = btn_prev & ~btn_sync;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			btn_sync <= '0;
			btn_prev <= '0;
			dir      <= DIR_RIGHT;
			game_on  <= 1'b0;
		end else begin
			btn_sync <= {display, mv_d, mv_u, mv_l, mv_r};
			btn_prev <= btn_sync;
			if (released[0])
				dir <= DIR_RIGHT;
			else if (released[1])
				dir <= DIR_LEFT;
			else if (released[2])
				dir <= DIR_UP;
			else if (released[3])
				dir <= DIR_DOWN;
			if (released[4])
				game_on <= ~game_on;
		end
	end

endmodule

/* hdl/frame_writer.sv */
`timescale 1ns/10ps

module frame_writer #(
	parameter int unsigned frame_gap = oled_pkg::DEF_FRAME_GAP
) (
	input  logic                clk,
	input  logic                rstn,
	input  logic                ready,
	input  logic                draw_done,
	input  logic                tx_busy,
	input  logic                tx_done,
	input  logic                pix_dout,
	output logic                frame_req,
	output logic                tx_start,
	output logic [7:0]          tx_byte,
	output logic                tx_dc,
	output oled_pkg::cell_loc_t pix_raddr
);
	import oled_pkg::*;

	logic [2:0]  state;
	logic [31:0] gap_cnt;
	logic [1:0]  page;
	logic [6:0]  col;
	logic [3:0]  bit_idx;	// 8 reads plus one for the read latency
	logic [1:0]  cmd_idx;
	logic [7:0]  data_byte;
	logic        issued;
	logic        can_start;

	assign can_start = !issued && !tx_busy && !tx_done;

	always_comb begin
		pix_raddr.loc.page    = page;
		pix_raddr.loc.col     = col;
		pix_raddr.loc.row_bit = bit_idx[2:0];
	end

	always_comb begin
		tx_dc   = 1'b0;
		tx_byte = CMD_ADDR_MODE;
		case (state)
		FW_MODE: tx_byte = (cmd_idx == 2'd0) ? CMD_ADDR_MODE : CMD_PAGE_MODE;
		FW_PAGE: case (cmd_idx)
			2'd0:    tx_byte = CMD_PAGE_ADDR;
			2'd1:    tx_byte = {6'd0, page};
			2'd2:    tx_byte = 8'h00;	// column low nibble
			default: tx_byte = 8'h10;	// column high nibble
			endcase
		FW_DATA: begin
			tx_byte = data_byte;
			tx_dc   = 1'b1;
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= FW_GAP;
			gap_cnt   <= '0;
			page      <= '0;
			col       <= '0;
			bit_idx   <= '0;
			cmd_idx   <= '0;
			data_byte <= '0;
			issued    <= 1'b0;
			tx_start  <= 1'b0;
			frame_req <= 1'b0;
		end else begin
			tx_start  <= 1'b0;
			frame_req <= 1'b0;
			if ((state == FW_MODE || state == FW_PAGE || state == FW_DATA) && can_start) begin
				tx_start <= 1'b1;
				issued   <= 1'b1;
			end
			case (state)
			FW_GAP: if (ready) begin
				if (gap_cnt == frame_gap - 1) begin
					gap_cnt   <= '0;
					frame_req <= 1'b1;
					state     <= FW_DRAW;
				end else
					gap_cnt <= gap_cnt + 1'b1;
			end
			FW_DRAW: if (draw_done) begin
				cmd_idx <= '0;
				state   <= FW_MODE;
			end
			FW_MODE: if (issued && tx_done) begin
				issued  <= 1'b0;
				cmd_idx <= cmd_idx + 1'b1;
				if (cmd_idx == 2'd1) begin
					cmd_idx <= '0;
					state   <= FW_PAGE;
				end
			end
			FW_PAGE: if (issued && tx_done) begin
				issued  <= 1'b0;
				cmd_idx <= cmd_idx + 1'b1;
				if (cmd_idx == 2'd3) begin
					col     <= '0;
					bit_idx <= '0;
					state   <= FW_LOAD;
				end
			end
			FW_LOAD: begin
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx != 4'd0)
					data_byte[3'(bit_idx - 4'd1)] <= pix_dout;	// previous address
				if (bit_idx == 4'd8)
					state <= FW_DATA;
			end
			FW_DATA: if (issued && tx_done) begin
				issued  <= 1'b0;
				bit_idx <= '0;
				col     <= col + 1'b1;
				state   <= FW_LOAD;
				if (col == 7'(N_COLS - 1)) begin
					page    <= page + 1'b1;
					cmd_idx <= '0;
					state   <= (page == 2'(N_PAGES - 1)) ? FW_GAP : FW_PAGE;
				end
			end
			default: state <= FW_GAP;
			endcase
		end
	end

endmodule

/* hdl/oled_pkg.sv */
package oled_pkg;

	localparam int CELL_W    = 12;
	localparam int SNAKE_LEN = 10;
	localparam int N_PAGES   = 4;
	localparam int N_COLS    = 128;

	localparam int BODY_IDX_W = $clog2(SNAKE_LEN);
	localparam logic [BODY_IDX_W-1:0] LAST_CELL = BODY_IDX_W'(SNAKE_LEN - 1);

	localparam int SCLK_HALF = 5;	// clk cycles per sclk half period
	localparam int BYTE_GAP  = 12;	// sclk held high after bit 8

	localparam int unsigned DEF_VDD_WAIT  = 32'd100000;
	localparam int unsigned DEF_RES_LOW   = 32'd100000;
	localparam int unsigned DEF_VBAT_WAIT = 32'd10000000;
	localparam int unsigned DEF_FRAME_GAP = 32'd5000000;

	localparam int N_INIT_CMDS = 12;
	localparam logic [7:0] INIT_CMDS [0:N_INIT_CMDS-1] = '{
		8'hAE, 8'h8D, 8'h14, 8'hD9, 8'hF1, 8'h81,
		8'h0F, 8'hA0, 8'hC0, 8'hDA, 8'h00, 8'hAF
	};

	localparam logic [7:0] CMD_ADDR_MODE = 8'h20;
	localparam logic [7:0] CMD_PAGE_MODE = 8'h10;
	localparam logic [7:0] CMD_PAGE_ADDR = 8'h22;

	localparam logic [1:0] DIR_RIGHT = 2'd0;
	localparam logic [1:0] DIR_LEFT  = 2'd1;
	localparam logic [1:0] DIR_DOWN  = 2'd2;
	localparam logic [1:0] DIR_UP    = 2'd3;

	// power-up sequencer states
	localparam logic [2:0] PS_VDD    = 3'd0;
	localparam logic [2:0] PS_SEND   = 3'd1;
	localparam logic [2:0] PS_RES_LO = 3'd2;
	localparam logic [2:0] PS_RES_HI = 3'd3;
	localparam logic [2:0] PS_VBAT   = 3'd4;
	localparam logic [2:0] PS_DONE   = 3'd5;

	// snake engine states
	localparam logic [2:0] SE_IDLE  = 3'd0;
	localparam logic [2:0] SE_PLACE = 3'd1;
	localparam logic [2:0] SE_MOVE  = 3'd2;
	localparam logic [2:0] SE_CLEAR = 3'd3;
	localparam logic [2:0] SE_DRAW  = 3'd4;

	// frame writer states
	localparam logic [2:0] FW_GAP  = 3'd0;
	localparam logic [2:0] FW_DRAW = 3'd1;
	localparam logic [2:0] FW_MODE = 3'd2;
	localparam logic [2:0] FW_PAGE = 3'd3;
	localparam logic [2:0] FW_LOAD = 3'd4;
	localparam logic [2:0] FW_DATA = 3'd5;

	// pixel address, same bit order as the panel's page layout
	typedef union packed {
		struct packed {
			logic [1:0] page;
			logic [6:0] col;
			logic [2:0] row_bit;
		} loc;
		logic [CELL_W-1:0] addr;
	} cell_loc_t;

endpackage

/* hdl/oled_power_seq.sv */
`timescale 1ns/10ps

module oled_power_seq #(
	parameter int unsigned vdd_wait  = oled_pkg::DEF_VDD_WAIT,
	parameter int unsigned res_low   = oled_pkg::DEF_RES_LOW,
	parameter int unsigned vbat_wait = oled_pkg::DEF_VBAT_WAIT
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       tx_busy,
	input  logic       tx_done,
	output logic       tx_start,
	output logic [7:0] tx_byte,
	output logic       tx_dc,
	output logic       oled_vdd,
	output logic       oled_res,
	output logic       oled_vbat,
	output logic       ready
);
	import oled_pkg::*;

	logic [2:0]  state;
	logic [31:0] wait_cnt;	// shared by all delays
	logic [3:0]  cmd_idx;
	logic        issued;	// byte handed to the shifter

	assign tx_byte = INIT_CMDS[cmd_idx];
	assign tx_dc   = 1'b0;	// config bytes are all commands

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= PS_VDD;
			wait_cnt  <= '0;
			cmd_idx   <= '0;
			issued    <= 1'b0;
			tx_start  <= 1'b0;
			oled_vdd  <= 1'b1;
			oled_res  <= 1'b1;
			oled_vbat <= 1'b1;
			ready     <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
			PS_VDD: begin
				oled_vdd <= 1'b0;
				if (wait_cnt == vdd_wait - 1) begin
					wait_cnt <= '0;
					state    <= PS_SEND;
				end else
					wait_cnt <= wait_cnt + 1'b1;
			end
			PS_SEND: begin
				if (!issued && !tx_busy && !tx_done) begin
					tx_start <= 1'b1;
					issued   <= 1'b1;
				end else if (issued && tx_done) begin
					issued <= 1'b0;
					if (cmd_idx == 4'd0)
						state <= PS_RES_LO;	// reset pulse right after display-off
					else if (cmd_idx == 4'd4)
						state <= PS_VBAT;	// charge pump and precharge done
					else if (cmd_idx == 4'(N_INIT_CMDS - 1)) begin
						ready <= 1'b1;
						state <= PS_DONE;
					end
					if (cmd_idx != 4'(N_INIT_CMDS - 1))
						cmd_idx <= cmd_idx + 1'b1;
				end
			end
			PS_RES_LO: begin
				oled_res <= 1'b0;
				if (wait_cnt == res_low - 1) begin
					wait_cnt <= '0;
					oled_res <= 1'b1;
					state    <= PS_RES_HI;
				end else
					wait_cnt <= wait_cnt + 1'b1;
			end
			PS_RES_HI: begin
				if (wait_cnt == res_low - 1) begin
					wait_cnt <= '0;
					state    <= PS_SEND;
				end else
					wait_cnt <= wait_cnt + 1'b1;
			end
			PS_VBAT: begin
				oled_vbat <= 1'b0;	// stays enabled from here on
				if (wait_cnt == vbat_wait - 1) begin
					wait_cnt <= '0;
					state    <= PS_SEND;
				end else
					wait_cnt <= wait_cnt + 1'b1;
			end
			default: ;	// PS_DONE, idle for good
			endcase
		end
	end

endmodule

/* hdl/oled_snake_top.sv */
`timescale 1ns/10ps

module oled_snake_top #(
	parameter int unsigned vdd_wait  = oled_pkg::DEF_VDD_WAIT,
	parameter int unsigned res_low   = oled_pkg::DEF_RES_LOW,
	parameter int unsigned vbat_wait = oled_pkg::DEF_VBAT_WAIT,
	parameter int unsigned frame_gap = oled_pkg::DEF_FRAME_GAP
) (
	input  logic clk,
	input  logic rstn,
	input  logic display,
	input  logic mv_l,
	input  logic mv_r,
	input  logic mv_u,
	input  logic mv_d,
	output logic oled_res,
	output logic oled_dc,
	output logic oled_sclk,
	output logic oled_sdin,
	output logic oled_vbat,
	output logic oled_vdd,
	output logic ready
);
	import oled_pkg::*;

	logic       ps_tx_start, fw_tx_start, tx_start;
	logic [7:0] ps_tx_byte, fw_tx_byte, tx_byte;
	logic       ps_tx_dc, fw_tx_dc, tx_dc;
	logic       tx_busy, tx_done;
	logic [1:0] dir;
	logic       game_on;
	logic       frame_req, draw_done;
	logic       pix_we, pix_din, pix_dout;
	cell_loc_t  pix_waddr, pix_raddr;

	// init owns the serial port until ready
	assign tx_start = ready ? fw_tx_start : ps_tx_start;
	assign tx_byte  = ready ? fw_tx_byte : ps_tx_byte;
	assign tx_dc    = ready ? fw_tx_dc : ps_tx_dc;

	oled_power_seq #(.vdd_wait(vdd_wait), .res_low(res_low), .vbat_wait(vbat_wait)) i_power_seq (
		.clk(clk), .rstn(rstn), .tx_busy(tx_busy), .tx_done(tx_done),
		.tx_start(ps_tx_start), .tx_byte(ps_tx_byte), .tx_dc(ps_tx_dc),
		.oled_vdd(oled_vdd), .oled_res(oled_res), .oled_vbat(oled_vbat), .ready(ready)
	);

	oled_spi_tx i_spi_tx (
		.clk(clk), .rstn(rstn), .tx_start(tx_start), .tx_byte(tx_byte), .tx_dc(tx_dc),
		.tx_busy(tx_busy), .tx_done(tx_done),
		.oled_sclk(oled_sclk), .oled_sdin(oled_sdin), .oled_dc(oled_dc)
	);

	button_ctrl i_button_ctrl (
		.clk(clk), .rstn(rstn), .mv_l(mv_l), .mv_r(mv_r), .mv_u(mv_u), .mv_d(mv_d),
		.display(display), .dir(dir), .game_on(game_on)
	);

	snake_engine i_snake_engine (
		.clk(clk), .rstn(rstn), .frame_req(frame_req), .dir(dir), .game_on(game_on),
		.draw_done(draw_done), .pix_we(pix_we), .pix_addr(pix_waddr), .pix_din(pix_din)
	);

	pixel_ram i_pixel_ram (
		.clk(clk), .we(pix_we), .waddr(pix_waddr), .din(pix_din),
		.raddr(pix_raddr), .dout(pix_dout)
	);

	frame_writer #(.frame_gap(frame_gap)) i_frame_writer (
		.clk(clk), .rstn(rstn), .ready(ready), .draw_done(draw_done),
		.tx_busy(tx_busy), .tx_done(tx_done), .pix_dout(pix_dout),
		.frame_req(frame_req), .tx_start(fw_tx_start), .tx_byte(fw_tx_byte),
		.tx_dc(fw_tx_dc), .pix_raddr(pix_raddr)
	);

endmodule

/* hdl/oled_spi_tx.sv */
`timescale 1ns/10ps

module oled_spi_tx (
	input  logic       clk,
	input  logic       rstn,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	input  logic       tx_dc,
	output logic       tx_busy,
	output logic       tx_done,
	output logic       oled_sclk,
	output logic       oled_sdin,
	output logic       oled_dc
);
	import oled_pkg::*;

	logic [$clog2(SCLK_HALF)-1:0] div_cnt;
	logic [$clog2(BYTE_GAP)-1:0]  gap_cnt;
	logic [7:0]                   shreg;
	logic [2:0]                   bit_cnt;	// rising edges seen
	logic                         in_gap;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			tx_busy   <= 1'b0;
			tx_done   <= 1'b0;
			oled_sclk <= 1'b1;
			oled_sdin <= 1'b1;
			oled_dc   <= 1'b0;
			shreg     <= '0;
			div_cnt   <= '0;
			gap_cnt   <= '0;
			bit_cnt   <= '0;
			in_gap    <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (tx_start && !tx_busy) begin
				tx_busy <= 1'b1;
				shreg   <= tx_byte;
				oled_dc <= tx_dc;	// held for the whole byte
				div_cnt <= '0;
				gap_cnt <= '0;
				bit_cnt <= '0;
				in_gap  <= 1'b0;
			end else if (tx_busy) begin
				if (in_gap) begin
					if (gap_cnt == BYTE_GAP - 1) begin
						tx_busy <= 1'b0;
						tx_done <= 1'b1;
					end else
						gap_cnt <= gap_cnt + 1'b1;
				end else if (div_cnt == SCLK_HALF - 1) begin
					div_cnt   <= '0;
					oled_sclk <= ~oled_sclk;
					if (oled_sclk) begin	// falling edge, next bit out
						oled_sdin <= shreg[7];
						shreg     <= {shreg[6:0], 1'b0};
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							in_gap <= 1'b1;	// sclk now rests high
					end
				end else
					div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

/* hdl/pixel_ram.sv */
`timescale 1ns/10ps

module pixel_ram (
	input  logic                clk,
	input  logic                we,
	input  oled_pkg::cell_loc_t waddr,
	input  logic                din,
	input  oled_pkg::cell_loc_t raddr,
	output logic                dout
);
	import oled_pkg::*;

	logic mem [0:2**CELL_W-1];	// one bit per pixel

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr.addr] <= din;
		dout <= mem[raddr.addr];
	end

endmodule

/* hdl/snake_engine.sv */
`timescale 1ns/10ps

module snake_engine (
	input  logic                clk,
	input  logic                rstn,
	input  logic                frame_req,
	input  logic [1:0]          dir,
	input  logic                game_on,
	output logic                draw_done,
	output logic                pix_we,
	output oled_pkg::cell_loc_t pix_addr,
	output logic                pix_din
);
	import oled_pkg::*;

	cell_loc_t               body [0:SNAKE_LEN-1];	// cell 0 is the head
	logic [2:0]              state;
	logic [BODY_IDX_W-1:0]   idx;
	logic [BODY_IDX_W-1:0]   rd_idx;
	logic [CELL_W-1:0]       clr_cnt;
	logic [1:0]              dir_q;
	logic                    game_on_q;
	logic                    place_pend;	// start body due at next frame
	logic                    shown;	// body has been placed once
	logic                    body_we;
	cell_loc_t               body_rd, body_wdata, start_cell, next_head;

	// during the shift each cell reads its predecessor
	assign rd_idx  = (state == SE_MOVE && idx != '0) ? idx - 1'b1 : idx;
	assign body_rd = body[rd_idx];

	always_comb begin
		start_cell = '0;
		start_cell.loc.col = 7'(SNAKE_LEN - 1) - 7'(idx);
	end

	always_comb begin
		next_head = body_rd;
		case (dir_q)
		DIR_RIGHT: next_head.loc.col = body_rd.loc.col + 7'd1;	// 127 wraps to 0
		DIR_LEFT:  next_head.loc.col = body_rd.loc.col - 7'd1;
		DIR_DOWN: begin
			next_head.loc.row_bit = body_rd.loc.row_bit + 3'd1;
			if (body_rd.loc.row_bit == 3'd7)
				next_head.loc.page = body_rd.loc.page + 2'd1;
		end
		default: begin
			next_head.loc.row_bit = body_rd.loc.row_bit - 3'd1;
			if (body_rd.loc.row_bit == 3'd0)
				next_head.loc.page = body_rd.loc.page - 2'd1;
		end
		endcase
	end

	always_comb begin
		body_we    = (state == SE_PLACE) || (state == SE_MOVE);
		body_wdata = start_cell;
		if (state == SE_MOVE)
			body_wdata = (idx == '0) ? next_head : body_rd;
	end

	always_ff @(posedge clk) begin
		if (body_we)
			body[idx] <= body_wdata;
	end

	always_comb begin
		pix_we        = (state == SE_CLEAR) || (state == SE_DRAW);
		pix_din       = (state == SE_DRAW);
		pix_addr.addr = clr_cnt;
		if (state == SE_DRAW)
			pix_addr = body_rd;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= SE_IDLE;
			idx        <= '0;
			clr_cnt    <= '0;
			dir_q      <= DIR_RIGHT;
			game_on_q  <= 1'b0;
			place_pend <= 1'b0;
			shown      <= 1'b0;
			draw_done  <= 1'b0;
		end else begin
			draw_done <= 1'b0;
			game_on_q <= game_on;
			case (state)
			SE_IDLE: if (frame_req) begin
				dir_q   <= dir;
				clr_cnt <= '0;
				if (place_pend) begin
					place_pend <= 1'b0;
					shown      <= 1'b1;
					idx        <= '0;
					state      <= SE_PLACE;
				end else if (game_on && shown) begin
					idx   <= LAST_CELL;	// tail first
					state <= SE_MOVE;
				end else
					state <= SE_CLEAR;
			end
			SE_PLACE: begin
				if (idx == LAST_CELL)
					state <= SE_CLEAR;
				else
					idx <= idx + 1'b1;
			end
			SE_MOVE: begin
				if (idx == '0)
					state <= SE_CLEAR;
				else
					idx <= idx - 1'b1;
			end
			SE_CLEAR: begin
				clr_cnt <= clr_cnt + 1'b1;
				idx     <= '0;
				if (clr_cnt == '1) begin
					if (shown)
						state <= SE_DRAW;
					else begin
						draw_done <= 1'b1;	// nothing to draw yet
						state     <= SE_IDLE;
					end
				end
			end
			SE_DRAW: begin
				if (idx == LAST_CELL) begin
					draw_done <= 1'b1;
					state     <= SE_IDLE;
				end else
					idx <= idx + 1'b1;
			end
			default: state <= SE_IDLE;
			endcase
			if (game_on && !game_on_q)
				place_pend <= 1'b1;
		end
	end

endmodule
